// ==== bus_pkg.sv ====
package bus_pkg;

  // data word and in-target address widths
  localparam int word_w = 16;
  localparam int word_addr_w = 14;
  localparam int sel_w = 2;

  // target chosen by cpu address bits 16:15
  typedef enum logic [sel_w-1:0] {
    sel_controller = 2'd0,
    sel_mod        = 2'd1,
    sel_normal     = 2'd2,
    sel_stm        = 2'd3
  } bram_select_t;

  typedef logic [word_w-1:0] word_t;
  typedef logic [word_addr_w-1:0] word_addr_t;

  // controller register map, word addresses
  localparam word_addr_t addr_mod_mem_wr_segment = 14'h0000;
  localparam word_addr_t addr_stm_mem_wr_segment = 14'h0001;
  localparam word_addr_t addr_stm_mem_wr_page = 14'h0002;
  localparam word_addr_t addr_ctl_flag = 14'h0003;

  // word of normal and stm banks
  typedef struct packed {
    logic [7:0] intensity;
    logic [7:0] phase;
  } intensity_phase_t;

  // two modulation samples per bus word
  typedef struct packed {
    logic [7:0] odd;
    logic [7:0] even;
  } mod_pair_t;

  // one decoded bus access, 33 bits
  typedef struct packed {
    logic         write;
    bram_select_t sel;
    word_addr_t   addr;
    word_t        data;
  } bus_req_t;

endpackage

// ==== bram_req_if.sv ====
interface bram_req_if;
  import bus_pkg::*;

  // high for one cycle per cpu access
  logic valid;
  // decoded access, stable while valid
  bus_req_t req;

  // driven by the decode stage
  modport src(
    output valid,
    output req
  );

  // register file and memory router listen in parallel
  // no ready, receivers always take the request
  modport dst(
    input valid,
    input req
  );

endinterface

// ==== bus_decode.sv ====
module bus_decode (
  input  logic           CPU_CKIO,
  input  logic           rst_n,
  input  logic [16:0]    addr,
  input  bus_pkg::word_t data_in,
  input  logic           cs1_n,
  input  logic           we0_n,
  input  logic           rd_n,
  bram_req_if.src        req
);
  import bus_pkg::*;

  // sampled bus
  logic [16:0] addr_q;
  word_t       data_q;
  logic        cs1_n_q;
  logic        we0_n_q;
  logic        rd_n_q;
  // strobe levels one cycle older
  logic        we0_n_prev;
  logic        rd_n_prev;

  logic wr_fall;
  logic rd_fall;
  logic wr_start;
  logic rd_start;
  logic start;

  // strobes idle high out of reset
  always_ff @(posedge CPU_CKIO) begin
    if (!rst_n) begin
      cs1_n_q    <= 1'b1;
      we0_n_q    <= 1'b1;
      rd_n_q     <= 1'b1;
      we0_n_prev <= 1'b1;
      rd_n_prev  <= 1'b1;
    end else begin
      cs1_n_q    <= cs1_n;
      we0_n_q    <= we0_n;
      rd_n_q     <= rd_n;
      we0_n_prev <= we0_n_q;
      rd_n_prev  <= rd_n_q;
    end
  end

  always_ff @(posedge CPU_CKIO) begin
    addr_q <= addr;
    data_q <= data_in;
  end

  // first low sample after a high one
  assign wr_fall = we0_n_prev & ~we0_n_q;
  // read only counts while write strobe is idle
  assign rd_fall = rd_n_prev & ~rd_n_q & we0_n_q;
  assign wr_start = wr_fall & ~cs1_n_q;
  assign rd_start = rd_fall & ~cs1_n_q;
  assign start = wr_start | rd_start;

  always_ff @(posedge CPU_CKIO) begin
    if (!rst_n) begin
      req.valid <= 1'b0;
    end else begin
      req.valid <= start;
    end
  end

  // split address into target and word address
  always_ff @(posedge CPU_CKIO) begin
    if (start) begin
      req.req <= '{write: wr_start,
                   sel: bram_select_t'(addr_q[16:15]),
                   addr: addr_q[14:1],
                   data: data_q};
    end
  end

  // a strobe edge outside chip select is a host fault
  a_strobe_in_cs: assert property (@(posedge CPU_CKIO) disable iff (!rst_n)
    (wr_fall || rd_fall) |-> !cs1_n_q)
    else $error("bus strobe started with cs1_n high");

  // pipeline has no back-pressure, accesses need four cycles apart
  a_access_spacing: assert property (@(posedge CPU_CKIO) disable iff (!rst_n)
    start |-> !($past(start, 1) || $past(start, 2) || $past(start, 3)))
    else $error("cpu accesses closer than four cycles");

endmodule

// ==== ctl_regs.sv ====
module ctl_regs #(
  parameter int stm_page_bits = 2
) (
  input  logic                     CPU_CKIO,
  input  logic                     rst_n,
  bram_req_if.dst                  req,
  output logic                     mod_wr_segment,
  output logic                     stm_wr_segment,
  output logic [stm_page_bits-1:0] stm_wr_page,
  output bus_pkg::word_t           ctl_rdata
);
  import bus_pkg::*;

  word_t ctl_flag;
  logic  ctl_hit;
  word_t rd_value;

  assign ctl_hit = req.valid & (req.req.sel == sel_controller);

  // register updates on controller writes
  always_ff @(posedge CPU_CKIO) begin
    if (!rst_n) begin
      mod_wr_segment <= 1'b0;
      stm_wr_segment <= 1'b0;
      stm_wr_page    <= '0;
      ctl_flag       <= '0;
    end else if (ctl_hit && req.req.write) begin
      case (req.req.addr)
        addr_mod_mem_wr_segment: mod_wr_segment <= req.req.data[0];
        addr_stm_mem_wr_segment: stm_wr_segment <= req.req.data[0];
        addr_stm_mem_wr_page:    stm_wr_page <= req.req.data[stm_page_bits-1:0];
        addr_ctl_flag:           ctl_flag <= req.req.data;
        // unmapped, write dropped
        default: ;
      endcase
    end
  end

  // readback mux, narrow registers zero extended
  always_comb begin
    case (req.req.addr)
      addr_mod_mem_wr_segment: rd_value = word_t'(mod_wr_segment);
      addr_stm_mem_wr_segment: rd_value = word_t'(stm_wr_segment);
      addr_stm_mem_wr_page:    rd_value = word_t'(stm_wr_page);
      addr_ctl_flag:           rd_value = ctl_flag;
      default:                 rd_value = '0;
    endcase
  end

  // same latency as the bank read port
  always_ff @(posedge CPU_CKIO) begin
    if (ctl_hit && !req.req.write) begin
      ctl_rdata <= rd_value;
    end
  end

endmodule

// ==== bram_bank.sv ====
module bram_bank #(
  parameter type word_t_p = logic [15:0],
  parameter int depth = 256,
  localparam int aw = $clog2(depth)
) (
  input  logic          CPU_CKIO,
  input  logic          en,
  input  logic          we,
  input  logic [aw-1:0] addr,
  input  word_t_p       wdata,
  output word_t_p       rdata
);

  word_t_p mem [depth];

  // single port, read returns the old word on a write cycle
  always_ff @(posedge CPU_CKIO) begin
    if (en) begin
      if (we) begin
        mem[addr] <= wdata;
      end
      rdata <= mem[addr];
    end
  end

  // catches address forming past the end of a non power of two bank
  a_addr_in_range: assert property (@(posedge CPU_CKIO)
    en |-> (int'(addr) < depth))
    else $error("bank address %0d beyond depth %0d", addr, depth);

endmodule

// ==== mem_router.sv ====
module mem_router #(
  parameter int num_trans = 249,
  parameter int mod_aw = 8,
  parameter int stm_offset_bits = 6,
  parameter int stm_page_bits = 2
) (
  input  logic                       CPU_CKIO,
  input  logic                       rst_n,
  bram_req_if.dst                    req,
  input  logic                       mod_wr_segment,
  input  logic                       stm_wr_segment,
  input  logic [stm_page_bits-1:0]   stm_wr_page,
  output bus_pkg::mod_pair_t         mod_rdata,
  output bus_pkg::intensity_phase_t  normal_rdata,
  output bus_pkg::intensity_phase_t  stm_rdata,
  output bus_pkg::bram_select_t      rd_sel,
  output logic                       rd_pending
);
  import bus_pkg::*;

  // modulation, segment bit above mod_aw word bits
  localparam int mod_depth = 2 ** (mod_aw + 1);
  // normal, two segments packed back to back
  localparam int nrm_depth = 2 * num_trans;
  localparam int nrm_aw = $clog2(nrm_depth);
  // stm, offset field above 8-bit transducer index
  localparam int stm_fw = stm_offset_bits + 8;
  localparam int stm_aw = 1 + stm_page_bits + stm_fw;
  localparam int stm_depth = 2 ** stm_aw;

  logic              wr;
  logic              rd;
  logic              mod_en;
  logic              nrm_en;
  logic              stm_en;
  logic [mod_aw:0]   mod_addr;
  logic              nrm_seg;
  logic [7:0]        nrm_idx;
  logic [nrm_aw-1:0] nrm_addr;
  logic [stm_aw-1:0] stm_addr;

  assign wr = req.valid & req.req.write;
  assign rd = req.valid & ~req.req.write;

  // one bank enabled per request
  assign mod_en = req.valid & (req.req.sel == sel_mod);
  assign nrm_en = req.valid & (req.req.sel == sel_normal);
  assign stm_en = req.valid & (req.req.sel == sel_stm);

  assign mod_addr = {mod_wr_segment, req.req.addr[mod_aw-1:0]};

  // address bit 8 picks the normal segment
  assign nrm_seg = req.req.addr[8];
  assign nrm_idx = req.req.addr[7:0];
  assign nrm_addr = nrm_seg ? nrm_aw'(nrm_idx) + nrm_aw'(num_trans) : nrm_aw'(nrm_idx);

  // segment, page, then offset and index from the bus
  assign stm_addr = {stm_wr_segment, stm_wr_page, req.req.addr[stm_fw-1:0]};

  bram_bank #(
    .word_t_p(mod_pair_t),
    .depth   (mod_depth)
  ) u_mod_bank (
    .CPU_CKIO(CPU_CKIO),
    .en      (mod_en),
    .we      (wr),
    .addr    (mod_addr),
    .wdata   (mod_pair_t'(req.req.data)),
    .rdata   (mod_rdata)
  );

  bram_bank #(
    .word_t_p(intensity_phase_t),
    .depth   (nrm_depth)
  ) u_normal_bank (
    .CPU_CKIO(CPU_CKIO),
    .en      (nrm_en),
    .we      (wr),
    .addr    (nrm_addr),
    .wdata   (intensity_phase_t'(req.req.data)),
    .rdata   (normal_rdata)
  );

  bram_bank #(
    .word_t_p(intensity_phase_t),
    .depth   (stm_depth)
  ) u_stm_bank (
    .CPU_CKIO(CPU_CKIO),
    .en      (stm_en),
    .we      (wr),
    .addr    (stm_addr),
    .wdata   (intensity_phase_t'(req.req.data)),
    .rdata   (stm_rdata)
  );

  // read target follows the bank latency
  always_ff @(posedge CPU_CKIO) begin
    if (!rst_n) begin
      rd_pending <= 1'b0;
      rd_sel     <= sel_controller;
    end else begin
      rd_pending <= rd;
      if (rd) begin
        rd_sel <= req.req.sel;
      end
    end
  end

endmodule

// ==== read_return.sv ====
module read_return (
  input  logic                      CPU_CKIO,
  input  logic                      rst_n,
  input  logic                      rd_pending,
  input  bus_pkg::bram_select_t     rd_sel,
  input  bus_pkg::word_t            ctl_rdata,
  input  bus_pkg::mod_pair_t        mod_rdata,
  input  bus_pkg::intensity_phase_t normal_rdata,
  input  bus_pkg::intensity_phase_t stm_rdata,
  output bus_pkg::word_t            data_out,
  output logic                      rdata_valid
);
  import bus_pkg::*;

  word_t rd_mux;

  // pick source of the pending read
  always_comb begin
    case (rd_sel)
      sel_controller: rd_mux = ctl_rdata;
      sel_mod:        rd_mux = word_t'(mod_rdata);
      sel_normal:     rd_mux = word_t'(normal_rdata);
      sel_stm:        rd_mux = word_t'(stm_rdata);
      default:        rd_mux = '0;
    endcase
  end

  // data held until the next read completes
  always_ff @(posedge CPU_CKIO) begin
    if (!rst_n) begin
      data_out    <= '0;
      rdata_valid <= 1'b0;
    end else begin
      rdata_valid <= rd_pending;
      if (rd_pending) begin
        data_out <= rd_mux;
      end
    end
  end

endmodule

// ==== memory_bus_top.sv ====
module memory_bus_top #(
  parameter int num_trans = 249,
  parameter int mod_aw = 8,
  parameter int stm_offset_bits = 6,
  parameter int stm_page_bits = 2
) (
  input  logic           CPU_CKIO,
  input  logic           rst_n,
  input  logic [16:0]    cpu_addr,
  input  bus_pkg::word_t cpu_data_in,
  input  logic           cpu_cs1_n,
  input  logic           cpu_we0_n,
  input  logic           cpu_rd_n,
  output bus_pkg::word_t cpu_data_out,
  output logic           cpu_rdata_valid
);
  import bus_pkg::*;

  logic                     mod_wr_segment;
  logic                     stm_wr_segment;
  logic [stm_page_bits-1:0] stm_wr_page;
  word_t                    ctl_rdata;
  mod_pair_t                mod_rdata;
  intensity_phase_t         normal_rdata;
  intensity_phase_t         stm_rdata;
  bram_select_t             rd_sel;
  logic                     rd_pending;

  // decoded request, one source and two listeners
  bram_req_if u_req ();

  bus_decode u_decode (
    .CPU_CKIO(CPU_CKIO),
    .rst_n   (rst_n),
    .addr    (cpu_addr),
    .data_in (cpu_data_in),
    .cs1_n   (cpu_cs1_n),
    .we0_n   (cpu_we0_n),
    .rd_n    (cpu_rd_n),
    .req     (u_req.src)
  );

  ctl_regs #(
    .stm_page_bits(stm_page_bits)
  ) u_ctl_regs (
    .CPU_CKIO      (CPU_CKIO),
    .rst_n         (rst_n),
    .req           (u_req.dst),
    .mod_wr_segment(mod_wr_segment),
    .stm_wr_segment(stm_wr_segment),
    .stm_wr_page   (stm_wr_page),
    .ctl_rdata     (ctl_rdata)
  );

  mem_router #(
    .num_trans      (num_trans),
    .mod_aw         (mod_aw),
    .stm_offset_bits(stm_offset_bits),
    .stm_page_bits  (stm_page_bits)
  ) u_router (
    .CPU_CKIO      (CPU_CKIO),
    .rst_n         (rst_n),
    .req           (u_req.dst),
    .mod_wr_segment(mod_wr_segment),
    .stm_wr_segment(stm_wr_segment),
    .stm_wr_page   (stm_wr_page),
    .mod_rdata     (mod_rdata),
    .normal_rdata  (normal_rdata),
    .stm_rdata     (stm_rdata),
    .rd_sel        (rd_sel),
    .rd_pending    (rd_pending)
  );

  read_return u_return (
    .CPU_CKIO    (CPU_CKIO),
    .rst_n       (rst_n),
    .rd_pending  (rd_pending),
    .rd_sel      (rd_sel),
    .ctl_rdata   (ctl_rdata),
    .mod_rdata   (mod_rdata),
    .normal_rdata(normal_rdata),
    .stm_rdata   (stm_rdata),
    .data_out    (cpu_data_out),
    .rdata_valid (cpu_rdata_valid)
  );

endmodule

// ==== tb_memory_bus.sv ====
module tb_memory_bus;
  timeunit 1ns;
  timeprecision 100ps;

  logic        CPU_CKIO;
  logic        rst_n;
  logic [16:0] cpu_addr;
  logic [15:0] cpu_data_in;
  logic        cpu_cs1_n;
  logic        cpu_we0_n;
  logic        cpu_rd_n;
  logic [15:0] cpu_data_out;
  logic        cpu_rdata_valid;

  int errors = 0;
  int checks = 0;
  int test_errors = 0;
  int test_checks = 0;
  int tests_done = 0;
  int cur_test = 0;
  int budget = 0;
  int seed;
  // reference copy of stm segment and page registers
  logic        stm_seg = 1'b0;
  logic [1:0]  stm_page = 2'd0;
  // stm contents keyed by {segment, page, word address}
  logic [15:0] stm_model [int];

  memory_bus_top dut (
    .CPU_CKIO       (CPU_CKIO),
    .rst_n          (rst_n),
    .cpu_addr       (cpu_addr),
    .cpu_data_in    (cpu_data_in),
    .cpu_cs1_n      (cpu_cs1_n),
    .cpu_we0_n      (cpu_we0_n),
    .cpu_rd_n       (cpu_rd_n),
    .cpu_data_out   (cpu_data_out),
    .cpu_rdata_valid(cpu_rdata_valid)
  );

  initial begin
    CPU_CKIO = 1'b0;
    forever #5 CPU_CKIO = ~CPU_CKIO;
  end

  task automatic check_value(input string what, input logic [15:0] exp, input logic [15:0] act);
    checks++;
    test_checks++;
    if (act !== exp) begin
      $display("[ERROR] %0t ns %s: expected %h, got %h", $time, what, exp, act);
      errors++;
      test_errors++;
    end
  endtask

  // one access is a setup cycle, then hold cycles of strobe low, then idle
  task automatic drive_access(input logic is_wr, input logic [1:0] tgt, input logic [13:0] addr,
                              input logic [15:0] data, input int hold, input int idle);
    @(posedge CPU_CKIO);
    cpu_cs1_n   <= 1'b0;
    cpu_addr    <= {tgt, addr, 1'b0};
    cpu_data_in <= data;
    @(posedge CPU_CKIO);
    if (is_wr) cpu_we0_n <= 1'b0;
    else cpu_rd_n <= 1'b0;
    repeat (hold) @(posedge CPU_CKIO);
    cpu_we0_n <= 1'b1;
    cpu_rd_n  <= 1'b1;
    cpu_cs1_n <= 1'b1;
    repeat (idle) @(posedge CPU_CKIO);
  endtask

  task automatic bus_write(input logic [1:0] tgt, input logic [13:0] addr,
                           input logic [15:0] data, input int hold, input int idle);
    drive_access(1'b1, tgt, addr, data, hold, idle);
    // follow the register file and stm bank
    if (tgt == 2'd0) begin
      case (addr)
        14'd1: stm_seg = data[0];
        14'd2: stm_page = data[1:0];
        default: ;
      endcase
    end else if (tgt == 2'd3) begin
      stm_model[int'({stm_seg, stm_page, addr})] = data;
    end
  endtask

  task automatic read_check(input logic [1:0] tgt, input logic [13:0] addr, input logic [15:0] exp);
    bit          got;
    logic [15:0] word;
    got = 1'b0;
    word = '0;
    drive_access(1'b0, tgt, addr, 16'h0000, 2, 0);
    // sample mid cycle away from the driving edge
    for (int i = 0; i < 8 && !got; i++) begin
      @(negedge CPU_CKIO);
      if (cpu_rdata_valid) begin
        got = 1'b1;
        word = cpu_data_out;
      end
    end
    if (!got) begin
      $display("read of target %0d address %h returned no data within eight cycles", tgt, addr);
      errors++;
      test_errors++;
    end else begin
      check_value($sformatf("read target %0d address %h", tgt, addr), exp, word);
    end
  endtask

  task automatic fill_stm(input logic [13:0] start, input int count);
    logic [15:0] rnd;
    for (int i = 0; i < count; i++) begin
      rnd = 16'($random(seed));
      bus_write(2'd3, start + 14'(i), rnd, 2, 2);
    end
  endtask

  // read back every stm entry and move segment and page as needed
  task automatic verify_stm();
    logic       seg;
    logic [1:0] pg;
    foreach (stm_model[k]) begin
      seg = k[16];
      pg = 2'(k >> 14);
      if (seg !== stm_seg) bus_write(2'd0, 14'd1, 16'(seg), 2, 2);
      if (pg !== stm_page) bus_write(2'd0, 14'd2, 16'(pg), 2, 2);
      read_check(2'd3, 14'(k), stm_model[k]);
    end
  endtask

  task automatic finish_test();
    if (cur_test != 0) begin
      $display("test %0d %s, %0d checks, %0d errors", cur_test,
               (test_errors == 0) ? "passed" : "failed", test_checks, test_errors);
      tests_done++;
    end
    test_checks = 0;
    test_errors = 0;
  endtask

  // run time limit from the vector file length
  initial begin
    wait (budget > 0);
    repeat (budget) @(posedge CPU_CKIO);
    $display("watchdog expired before the vector file was finished");
    $display("TEST FAILED");
    $finish;
  end

  initial begin
    int          fd;
    int          n;
    int          units;
    int          test_v;
    string       line;
    byte         op_v;
    logic [1:0]  tgt_v;
    logic [13:0] addr_v;
    logic [15:0] data_v;
    seed = 32'hf7b5_e545;
    units = 0;
    rst_n       <= 1'b0;
    cpu_addr    <= '0;
    cpu_data_in <= '0;
    cpu_cs1_n   <= 1'b1;
    cpu_we0_n   <= 1'b1;
    cpu_rd_n    <= 1'b1;
    fd = $fopen("bus_vectors.txt", "r");
    if (fd == 0) begin
      $display("could not open bus_vectors.txt");
      $display("TEST FAILED");
      $finish;
    end else begin
      // first pass sizes the watchdog with stm fills weighed by count
      while ($fgets(line, fd) != 0) begin
        n = $sscanf(line, "%c %d %d %h %h", op_v, test_v, tgt_v, addr_v, data_v);
        if (n == 5) units += (op_v == "S") ? 1 + 3 * int'(data_v) : 2;
      end
      $fclose(fd);
      budget = units * 20 + 1000;
      repeat (5) @(posedge CPU_CKIO);
      rst_n <= 1'b1;
      fd = $fopen("bus_vectors.txt", "r");
      while ($fgets(line, fd) != 0) begin
        n = $sscanf(line, "%c %d %d %h %h", op_v, test_v, tgt_v, addr_v, data_v);
        if (n == 5) begin
          if (test_v != cur_test) begin
            finish_test();
            cur_test = test_v;
          end
          case (op_v)
            "W": bus_write(tgt_v, addr_v, data_v, 2, 2);
            "H": bus_write(tgt_v, addr_v, data_v, 5, 2);
            "R": read_check(tgt_v, addr_v, data_v);
            // read issued at the minimum spacing behind the write
            "B": begin
              bus_write(tgt_v, addr_v, data_v, 2, 0);
              read_check(tgt_v, addr_v, data_v);
            end
            "S": begin
              if (data_v == 16'd0) verify_stm();
              else fill_stm(addr_v, int'(data_v));
            end
            default: begin
              $display("unknown operation code in vector file line: %s", line);
              errors++;
            end
          endcase
        end
      end
      $fclose(fd);
      finish_test();
      $display("%0d tests, %0d checks, %0d errors", tests_done, checks, errors);
      if (errors == 0) begin
        $display("TEST OK");
      end else begin
        $display("TEST FAILED");
      end
      $finish;
    end
  end

endmodule

// ==== bus_vectors.txt ====
# op test target word_addr data (hex), R and B data is the expected read value
# W write, R read, B write then read at min spacing, H long write strobe, S stm fill count or 0 to verify
R 1 0 0000 0000
R 1 0 0001 0000
R 1 0 0002 0000
R 1 0 0003 0000
W 1 0 0020 beef
R 1 0 0020 0000
W 2 1 0005 a15c
W 2 0 0000 0001
W 2 1 0005 3c7e
R 2 1 0005 3c7e
W 2 0 0000 0000
R 2 1 0005 a15c
W 3 2 0000 1122
W 3 2 00f8 3344
W 3 2 0100 5566
W 3 2 01f8 7788
R 3 2 0000 1122
R 3 2 00f8 3344
R 3 2 0100 5566
R 3 2 01f8 7788
W 4 3 0040 a001
W 4 0 0002 0001
W 4 3 0040 a002
W 4 0 0001 0001
W 4 3 0040 a003
R 4 3 0040 a003
W 4 0 0001 0000
R 4 3 0040 a002
W 4 0 0002 0000
R 4 3 0040 a001
W 5 0 0002 0001
S 5 3 0010 0008
W 5 0 0002 0002
S 5 3 0010 0008
S 5 3 0000 0000
B 6 2 0010 c0de
B 6 0 0003 0f0f
H 6 2 0011 1234
H 6 2 0011 5678
R 6 2 0011 5678

// ==== src.f ====
bus_pkg.sv
bram_req_if.sv
bus_decode.sv
ctl_regs.sv
bram_bank.sv
mem_router.sv
read_return.sv
memory_bus_top.sv
tb_memory_bus.sv

// ==== run.sh ====
#!/bin/sh
# build and run the memory bus testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module tb_memory_bus -f src.f -Mdir obj_dir -o tb_memory_bus
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tb_memory_bus > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "TEST FAILED" sim.log; then
  exit 1
fi
exit 0
